//--- Makefile
# Verilator build, run and lint for the BK-0010 debug subsystem

TOP := tb_bk_dbg
LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): list.f $(wildcard rtl/*.sv dv/*.sv)
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f list.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "Run failed"; exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG) || (echo "No pass message in $(LOG)"; exit 1)

lint:
	verilator --lint-only --timescale 1ns/1ps --top-module bk_dbg_top \
		rtl/bk_dbg_pkg.sv rtl/sram_wb_ctrl.sv rtl/bus_monitor.sv \
		rtl/hex4_display.sv rtl/bk_dbg_top.sv
	verilator --lint-only --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f list.f

clean:
	rm -rf obj_dir $(LOG)

//--- dv/sram_model.sv
/*
 * Asynchronous 16-bit SRAM with byte lanes, simulation model
 * Tristate data bus, write lands while we_n is low
 */

`timescale 1ns/1ps
`default_nettype none

module sram_model (
	input  wire  [bk_dbg_pkg::ADDR_W-1:0] addr,
	input  wire                           ce_n,
	input  wire                           oe_n,
	input  wire                           we_n,
	input  wire                           lb_n,
	input  wire                           ub_n,
	inout  wire  [bk_dbg_pkg::DATA_W-1:0] dq
);
	import bk_dbg_pkg::*;

	logic [DATA_W-1:0] mem [0:(1 << ADDR_W)-1];
	logic              rd_en;

	// Power-up contents, every address bit takes part
	initial begin
		for (int i = 0; i < (1 << ADDR_W); i++)
			mem[i] = 16'hc35a ^ i[15:0] ^ {i[17:16], 14'd0};
	end

	// Read path, whole word while OE is low
	assign rd_en = !ce_n && !oe_n && we_n;
	assign dq    = rd_en ? mem[addr] : {DATA_W{1'bz}};

	// Write pulse
	always @(negedge we_n) begin
		#1;  // Address, lanes and data settle
		if (!ce_n && !we_n) begin
			if (!lb_n)
				mem[addr][7:0] = dq[7:0];
			if (!ub_n)
				mem[addr][15:8] = dq[15:8];  // High lane
		end
	end

endmodule

`default_nettype wire

//--- dv/tb_bk_dbg.sv
/*
 * Testbench for the BK-0010 debug subsystem
 * Table of Wishbone accesses against a shadow memory, latency and display checks
 */

`timescale 1ns/1ps
`default_nettype none

module tb_bk_dbg;
	import bk_dbg_pkg::*;

	localparam int ROW_CYCLES = 20;  // Budget per table row
	localparam int N_RANDOM   = 40;

	typedef enum logic [1:0] {OP_RD, OP_WR, OP_FETCH} op_t;

	typedef struct {
		string             name;
		logic              we;
		logic              fetch;
		logic [ADDR_W-1:0] adr;
		logic [SEL_W-1:0]  sel;
		logic [DATA_W-1:0] wdat;
		disp_sel_t         dsel;      // Switches during the access
		logic [DATA_W-1:0] exp_disp;  // Worked out by hand
		logic              has_exp;
		int                gap;       // Idle cycles after the row
	} row_t;

	logic              clk25 = 1'b0;
	logic              rst_n;
	wb_req_t           wb_req;
	disp_sel_t         sw_sel;
	logic [DATA_W-1:0] wb_dat_r;
	logic              wb_ack;
	logic [6:0]        hex0;
	logic [6:0]        hex1;
	logic [6:0]        hex2;
	logic [6:0]        hex3;
	logic [ADDR_W-1:0] sram_addr;
	logic              sram_ce_n;
	logic              sram_oe_n;
	logic              sram_we_n;
	logic              sram_lb_n;
	logic              sram_ub_n;
	wire  [DATA_W-1:0] sram_dq;

	row_t              rows[$];
	logic [DATA_W-1:0] shadow [int];   // Words written so far
	logic              exp_from_table; // Rows being added carry a hand value
	logic              table_ready;
	integer            seed;
	// Expected monitor registers
	logic [DATA_W-1:0] m_fetch_adr;
	logic [DATA_W-1:0] m_opcode;
	logic [DATA_W-1:0] m_write_adr;
	logic [DATA_W-1:0] m_last_data;

	// DE1 segments g..a, active low, index is the nibble
	logic [6:0] seg_tab [16] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
		7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e};

	bk_dbg_top bk_dbg_top_i (
		.clk25     (clk25),
		.rst_n     (rst_n),
		.wb_req    (wb_req),
		.sw_sel    (sw_sel),
		.wb_dat_r  (wb_dat_r),
		.wb_ack    (wb_ack),
		.hex0      (hex0),
		.hex1      (hex1),
		.hex2      (hex2),
		.hex3      (hex3),
		.sram_addr (sram_addr),
		.sram_ce_n (sram_ce_n),
		.sram_oe_n (sram_oe_n),
		.sram_we_n (sram_we_n),
		.sram_lb_n (sram_lb_n),
		.sram_ub_n (sram_ub_n),
		.sram_dq   (sram_dq)
	);

	sram_model sram_model_i (
		.addr (sram_addr),
		.ce_n (sram_ce_n),
		.oe_n (sram_oe_n),
		.we_n (sram_we_n),
		.lb_n (sram_lb_n),
		.ub_n (sram_ub_n),
		.dq   (sram_dq)
	);

	always #2 clk25 = ~clk25;  // 4 ns period

	// ==============================
	// Reference rules
	// ==============================
	// Same power-up rule as the SRAM model
	function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] a);
		return 16'hc35a ^ a[15:0] ^ {a[17:16], 14'd0};
	endfunction

	function automatic logic [DATA_W-1:0] shadow_read(input logic [ADDR_W-1:0] a);
		if (shadow.exists(int'(a)))
			return shadow[int'(a)];
		return fill_word(a);
	endfunction

	// Selected lanes take new bytes and the rest keep the old word
	function automatic logic [DATA_W-1:0] apply_byte_lanes(input logic [SEL_W-1:0] sel,
			input logic [DATA_W-1:0] new_w, input logic [DATA_W-1:0] old_w);
		logic [DATA_W-1:0] mask;
		mask = {{8{sel[1]}}, {8{sel[0]}}};
		return (new_w & mask) | (old_w & ~mask);
	endfunction

	function automatic logic [DATA_W-1:0] selected_word(input disp_sel_t s);
		case (s)
			DISP_FETCH_ADR: return m_fetch_adr;
			DISP_WRITE_ADR: return m_write_adr;
			DISP_OPCODE:    return m_opcode;
			default:        return m_last_data;
		endcase
	endfunction

	// hex3 down to hex0
	function automatic logic [27:0] digits_of(input logic [DATA_W-1:0] w);
		return {seg_tab[w[15:12]], seg_tab[w[11:8]], seg_tab[w[7:4]], seg_tab[w[3:0]]};
	endfunction

	// ==============================
	// Reporting and timing helpers
	// ==============================
	task automatic stop_run(input string why);
		$display("%s", why);
		$display("SIMULATION FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			stop_run($sformatf("ERR %s expected %0h actual %0h", name, exp, act));
		end
	endtask

	task automatic step_cycle();
		@(posedge clk25);
		#0.5;  // Drive and sample point
	endtask

	task automatic add_row(input string name, input op_t op, input logic [ADDR_W-1:0] adr,
			input logic [SEL_W-1:0] sel, input logic [DATA_W-1:0] wdat,
			input disp_sel_t dsel, input logic [DATA_W-1:0] exp_disp, input int gap);
		row_t r;
		r.name     = name;
		r.we       = (op == OP_WR);
		r.fetch    = (op == OP_FETCH);
		r.adr      = adr;
		r.sel      = sel;
		r.wdat     = wdat;
		r.dsel     = dsel;
		r.exp_disp = exp_disp;
		r.has_exp  = exp_from_table;
		r.gap      = gap;
		rows.push_back(r);
	endtask

	// ==============================
	// Stimulus table
	// ==============================
	task automatic build_table();
		logic [31:0] rnd_a;
		logic [31:0] rnd_d;
		op_t         op;
		exp_from_table = 1'b1;
		add_row("wr_full_a",   OP_WR, 18'h00100, 2'b11, 16'h1234, DISP_WRITE_ADR, 16'h0100, 0);
		add_row("rd_full_a",   OP_RD, 18'h00100, 2'b11, 16'h0000, DISP_LAST_DATA, 16'h1234, 1);
		add_row("wr_full_b",   OP_WR, 18'h2abcd, 2'b11, 16'h0a5f, DISP_WRITE_ADR, 16'habcd, 0);
		add_row("wr_byte_lo",  OP_WR, 18'h00100, 2'b01, 16'hffee, DISP_LAST_DATA, 16'h12ee, 0);
		add_row("wr_byte_hi",  OP_WR, 18'h00100, 2'b10, 16'h77aa, DISP_LAST_DATA, 16'h77ee, 2);
		add_row("rd_merged",   OP_RD, 18'h00100, 2'b11, 16'h0000, DISP_LAST_DATA, 16'h77ee, 0);
		add_row("wr_opcode",   OP_WR, 18'h01000, 2'b11, 16'h0a37, DISP_WRITE_ADR, 16'h1000, 0);
		add_row("fetch_a",  OP_FETCH, 18'h01000, 2'b11, 16'h0000, DISP_FETCH_ADR, 16'h1000, 3);
		add_row("rd_keep_fa",  OP_RD, 18'h2abcd, 2'b11, 16'h0000, DISP_FETCH_ADR, 16'h1000, 0);
		add_row("rd_keep_opc", OP_RD, 18'h00100, 2'b11, 16'h0000, DISP_OPCODE,    16'h0a37, 4);
		add_row("rd_keep_wa",  OP_RD, 18'h2abcd, 2'b11, 16'h0000, DISP_WRITE_ADR, 16'h1000, 0);
		add_row("fetch_b",  OP_FETCH, 18'h2abcd, 2'b11, 16'h0000, DISP_OPCODE,    16'h0a5f, 1);
		// Byte write into untouched memory keeps the fill in the low byte
		add_row("wr_byte_new", OP_WR, 18'h3f00f, 2'b10, 16'h5500, DISP_LAST_DATA, 16'h5555, 0);
		add_row("rd_byte_new", OP_RD, 18'h3f00f, 2'b11, 16'h0000, DISP_WRITE_ADR, 16'hf00f, 0);

		// Random rows on a small address pool, so reads hit earlier writes
		exp_from_table = 1'b0;
		for (int i = 0; i < N_RANDOM; i++) begin
			rnd_a = $random(seed);
			rnd_d = $random(seed);
			if (rnd_d[31])
				op = OP_WR;
			else
				op = rnd_d[30] ? OP_FETCH : OP_RD;
			add_row($sformatf("rnd_%0d", i), op, rnd_a[17:0] & 18'h3f00f,
				(op == OP_WR && rnd_d[21:20] != 2'b00) ? rnd_d[21:20] : 2'b11,
				rnd_d[15:0], disp_sel_t'(rnd_a[25:24]), 16'h0000, int'(rnd_a[27:26]));
		end
	endtask

	// ==============================
	// One access and its display checks
	// ==============================
	task automatic run_row(input row_t r);
		int                edges;
		int                exp_lat;
		logic [DATA_W-1:0] new_word;
		logic [DATA_W-1:0] exp_word;
		sw_sel       = r.dsel;
		wb_req.cyc   = 1'b1;
		wb_req.stb   = 1'b1;
		wb_req.we    = r.we;
		wb_req.sel   = r.sel;
		wb_req.adr   = r.adr;
		wb_req.dat   = r.wdat;
		wb_req.fetch = r.fetch;
		edges = 0;
		do begin
			step_cycle();
			edges++;
		end while (!wb_ack && edges < 16);
		if (!wb_ack)
			stop_run($sformatf("%s: no ack within %0d cycles", r.name, edges));
		exp_lat = (r.we && r.sel != 2'b11) ? 3 : 2;  // Byte write adds the merge read
		check({r.name, " ack latency"}, 32'(exp_lat), 32'(edges));
		check({r.name, " sram address"}, 32'(r.adr), 32'(sram_addr));

		if (r.we) begin
			new_word = apply_byte_lanes(r.sel, r.wdat, shadow_read(r.adr));
			shadow[int'(r.adr)] = new_word;
			m_write_adr = r.adr[DATA_W-1:0];
			m_last_data = new_word;
		end else begin
			check({r.name, " read data"}, 32'(shadow_read(r.adr)), 32'(wb_dat_r));
			m_last_data = shadow_read(r.adr);
			if (r.fetch) begin
				m_fetch_adr = r.adr[DATA_W-1:0];
				m_opcode    = shadow_read(r.adr);
			end
		end

		step_cycle();  // Request held through the edge that samples ack
		wb_req = '0;
		repeat (2) step_cycle();  // Monitor, select, digit registers
		exp_word = r.has_exp ? r.exp_disp : selected_word(r.dsel);
		check({r.name, " display"}, 32'(digits_of(exp_word)), 32'({hex3, hex2, hex1, hex0}));

		// Every source through the switches
		for (int s = 0; s < 4; s++) begin
			sw_sel = disp_sel_t'(s[1:0]);
			repeat (2) step_cycle();
			check($sformatf("%s sw_sel %0d", r.name, s), 32'(digits_of(selected_word(sw_sel))),
				32'({hex3, hex2, hex1, hex0}));
		end
		repeat (r.gap) step_cycle();  // Idle bus
	endtask

	// ==============================
	// Main sequence
	// ==============================
	initial begin
		rst_n          = 1'b0;
		wb_req         = '0;
		sw_sel         = DISP_FETCH_ADR;
		table_ready    = 1'b0;
		exp_from_table = 1'b1;
		m_fetch_adr    = '0;
		m_opcode       = '0;
		m_write_adr    = '0;
		m_last_data    = '0;
		seed           = 78292;
		build_table();
		table_ready = 1'b1;

		repeat (10) @(posedge clk25);
		#0.5;
		rst_n = 1'b1;
		step_cycle();
		check("reset ack", 32'(1'b0), 32'(wb_ack));
		check("reset strobes", 32'(5'b11111),
			32'({sram_ce_n, sram_oe_n, sram_we_n, sram_lb_n, sram_ub_n}));
		check("reset digits", 32'(digits_of(16'h0000)), 32'({hex3, hex2, hex1, hex0}));

		foreach (rows[i])
			run_row(rows[i]);

		$display("SIMULATION PASSED");
		$finish;
	end

	// Watchdog sized from the table
	initial begin
		wait (table_ready);
		#(rows.size() * ROW_CYCLES * 4 + 10 * 4);
		stop_run("timeout waiting for ack");
	end

endmodule

`default_nettype wire

//--- list.f
rtl/bk_dbg_pkg.sv
rtl/sram_wb_ctrl.sv
rtl/bus_monitor.sv
rtl/hex4_display.sv
rtl/bk_dbg_top.sv
dv/sram_model.sv
dv/tb_bk_dbg.sv

//--- rtl/bk_dbg_pkg.sv
/*
 * BK-0010 debug subsystem shared definitions
 * Bus widths, Wishbone request and bus observation records, display sources
 */

`default_nettype none

package bk_dbg_pkg;

	// ==============================
	// Bus geometry
	// ==============================
	localparam int ADDR_W = 18;  // SRAM word address
	localparam int DATA_W = 16;
	localparam int SEL_W  = 2;   // Byte lanes

	// ==============================
	// Wishbone classic request
	// ==============================
	// Held steady by the CPU side until ack
	typedef struct packed {
		logic              cyc;
		logic              stb;
		logic              we;
		logic [SEL_W-1:0]  sel;    // Bit 0 low byte, bit 1 high byte
		logic [ADDR_W-1:0] adr;
		logic [DATA_W-1:0] dat;    // Write data
		logic              fetch;  // Address tag, instruction fetch
	} wb_req_t;                    // 40 bits

	// ==============================
	// Completed access, one cycle
	// ==============================
	typedef struct packed {
		logic              valid;  // High in the ack cycle only
		logic              we;
		logic              fetch;
		logic [ADDR_W-1:0] adr;
		// Read data, or for a write the resulting word after the lane merge
		logic [DATA_W-1:0] dat;
	} bus_obs_t;                   // 37 bits

	// Display source, from the board switches
	typedef enum logic [1:0] {
		DISP_FETCH_ADR = 2'd0,  // Low 16 bits of the address
		DISP_WRITE_ADR = 2'd1,  // Low 16 bits as well
		DISP_OPCODE    = 2'd2,
		DISP_LAST_DATA = 2'd3
	} disp_sel_t;

endpackage

`default_nettype wire

//--- rtl/bk_dbg_top.sv
/*
 * BK-0010 debug and memory subsystem, top level
 * SRAM controller, bus monitor and hex display on one clock
 */

`timescale 1ns/1ps
`default_nettype none

module bk_dbg_top (
	input  wire                              clk25,
	input  wire                              rst_n,
	input  bk_dbg_pkg::wb_req_t              wb_req,
	input  bk_dbg_pkg::disp_sel_t            sw_sel,
	output logic [bk_dbg_pkg::DATA_W-1:0]    wb_dat_r,
	output logic                             wb_ack,
	output logic [6:0]                       hex0,
	output logic [6:0]                       hex1,
	output logic [6:0]                       hex2,
	output logic [6:0]                       hex3,
	output logic [bk_dbg_pkg::ADDR_W-1:0]    sram_addr,
	output logic                             sram_ce_n,
	output logic                             sram_oe_n,
	output logic                             sram_we_n,
	output logic                             sram_lb_n,
	output logic                             sram_ub_n,
	inout  wire  [bk_dbg_pkg::DATA_W-1:0]    sram_dq
);
	import bk_dbg_pkg::*;

	bus_obs_t          obs;        // One record per completed access
	logic [DATA_W-1:0] disp_word;  // Selected debug word

	// ==============================
	// Memory side
	// ==============================
	sram_wb_ctrl sram_wb_ctrl_i (
		.clk25     (clk25),
		.rst_n     (rst_n),
		.wb_req    (wb_req),
		.wb_dat_r  (wb_dat_r),
		.wb_ack    (wb_ack),
		.obs       (obs),
		.sram_addr (sram_addr),
		.sram_ce_n (sram_ce_n),
		.sram_oe_n (sram_oe_n),
		.sram_we_n (sram_we_n),
		.sram_lb_n (sram_lb_n),
		.sram_ub_n (sram_ub_n),
		.sram_dq   (sram_dq)
	);

	bus_monitor bus_monitor_i (
		.clk25     (clk25),
		.rst_n     (rst_n),
		.obs       (obs),
		.sw_sel    (sw_sel),
		.disp_word (disp_word)
	);

	hex4_display hex4_display_i (
		.clk25 (clk25),
		.rst_n (rst_n),
		.word  (disp_word),
		.hex0  (hex0),
		.hex1  (hex1),
		.hex2  (hex2),
		.hex3  (hex3)
	);

endmodule

`default_nettype wire

//--- rtl/bus_monitor.sv
/*
 * Bus monitor
 * Keeps fetch address, opcode, last write address and last data word,
 * and picks one of them for the hex display
 */

`timescale 1ns/1ps
`default_nettype none

module bus_monitor (
	input  wire                            clk25,
	input  wire                            rst_n,
	input  bk_dbg_pkg::bus_obs_t           obs,
	input  bk_dbg_pkg::disp_sel_t          sw_sel,
	output logic [bk_dbg_pkg::DATA_W-1:0]  disp_word
);
	import bk_dbg_pkg::*;

	logic [DATA_W-1:0] fetch_adr;  // Low 16 bits shown
	logic [DATA_W-1:0] opcode;
	logic [DATA_W-1:0] write_adr;
	logic [DATA_W-1:0] last_data;

	// ==============================
	// Captures
	// ==============================
	always_ff @(posedge clk25 or negedge rst_n) begin
		if (!rst_n) begin
			fetch_adr <= '0;
			opcode    <= '0;
			write_adr <= '0;
			last_data <= '0;
		end else if (obs.valid) begin
			if (obs.fetch && !obs.we) begin
				fetch_adr <= obs.adr[DATA_W-1:0];
				opcode    <= obs.dat;  // Instruction word
			end
			if (obs.we)
				write_adr <= obs.adr[DATA_W-1:0];
			last_data <= obs.dat;  // Reads and writes alike
		end
	end

	// ==============================
	// Display select
	// ==============================
	always_ff @(posedge clk25 or negedge rst_n) begin
		if (!rst_n) begin
			disp_word <= '0;
		end else begin
			case (sw_sel)
				DISP_FETCH_ADR: disp_word <= fetch_adr;
				DISP_WRITE_ADR: disp_word <= write_adr;  // Stands in for SP
				DISP_OPCODE:    disp_word <= opcode;
				DISP_LAST_DATA: disp_word <= last_data;
				default:        disp_word <= '0;
			endcase
		end
	end

	// Fetch tag only ever rides on reads from the CPU side
	a_fetch_read: assert property (@(posedge clk25) disable iff (!rst_n)
		obs.valid |-> !(obs.fetch && obs.we));

endmodule

`default_nettype wire

//--- rtl/hex4_display.sv
/*
 * Four-digit hex display driver
 * Active-low seven-segment codes in DE1 order, hex0 is the low nibble
 */

`timescale 1ns/1ps
`default_nettype none

module hex4_display (
	input  wire         clk25,
	input  wire         rst_n,
	input  wire  [15:0] word,
	output logic [6:0]  hex0,
	output logic [6:0]  hex1,
	output logic [6:0]  hex2,
	output logic [6:0]  hex3
);
	// Segment bits g..a with low meaning lit
	function automatic logic [6:0] seg7(input logic [3:0] nib);
		case (nib)
			4'h0: return 7'b1000000;
			4'h1: return 7'b1111001;
			4'h2: return 7'b0100100;
			4'h3: return 7'b0110000;
			4'h4: return 7'b0011001;
			4'h5: return 7'b0010010;
			4'h6: return 7'b0000010;
			4'h7: return 7'b1111000;
			4'h8: return 7'b0000000;
			4'h9: return 7'b0010000;
			4'ha: return 7'b0001000;
			4'hb: return 7'b0000011;  // Lower case b
			4'hc: return 7'b1000110;
			4'hd: return 7'b0100001;  // Lower case d
			4'he: return 7'b0000110;
			default: return 7'b0001110;  // F
		endcase
	endfunction

	always_ff @(posedge clk25 or negedge rst_n) begin
		if (!rst_n) begin
			hex0 <= 7'b1000000;  // Shows 0000
			hex1 <= 7'b1000000;
			hex2 <= 7'b1000000;
			hex3 <= 7'b1000000;
		end else begin
			hex0 <= seg7(word[3:0]);
			hex1 <= seg7(word[7:4]);
			hex2 <= seg7(word[11:8]);
			hex3 <= seg7(word[15:12]);
		end
	end

endmodule

`default_nettype wire

//--- rtl/sram_wb_ctrl.sv
/*
 * Wishbone classic slave for the 16-bit asynchronous board SRAM
 * Two-edge read or write, three edges for a byte write (merge-read first)
 * Reports every completed access as one observation
 */

`timescale 1ns/1ps
`default_nettype none

module sram_wb_ctrl (
	input  wire                              clk25,
	input  wire                              rst_n,
	input  bk_dbg_pkg::wb_req_t              wb_req,
	output logic [bk_dbg_pkg::DATA_W-1:0]    wb_dat_r,
	output logic                             wb_ack,
	output bk_dbg_pkg::bus_obs_t             obs,
	output logic [bk_dbg_pkg::ADDR_W-1:0]    sram_addr,
	output logic                             sram_ce_n,
	output logic                             sram_oe_n,
	output logic                             sram_we_n,
	output logic                             sram_lb_n,
	output logic                             sram_ub_n,
	inout  wire  [bk_dbg_pkg::DATA_W-1:0]    sram_dq
);
	import bk_dbg_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_READ,
		ST_WRITE,
		ST_MERGE_RD  // Old word read ahead of a byte write
	} state_t;

	state_t            state;
	wb_req_t           req_q;      // Latched request
	logic [DATA_W-1:0] wr_data;    // Word driven onto sram_dq
	logic [DATA_W-1:0] data_q;     // Read data or resulting write word
	logic              dq_oe;      // Tristate enable of sram_dq
	logic              obs_valid;
	logic              start;
	logic              partial;

	// Replace only the selected lanes of the old word
	function automatic logic [DATA_W-1:0] lane_merge(input logic [SEL_W-1:0] sel,
			input logic [DATA_W-1:0] new_w, input logic [DATA_W-1:0] old_w);
		logic [DATA_W-1:0] res;
		res[7:0]  = sel[0] ? new_w[7:0]  : old_w[7:0];
		res[15:8] = sel[1] ? new_w[15:8] : old_w[15:8];
		return res;
	endfunction

	assign start   = (state == ST_IDLE) && wb_req.cyc && wb_req.stb && !wb_ack;  // New cycle
	assign partial = wb_req.sel != {SEL_W{1'b1}};

	// ==============================
	// Control and strobes
	// ==============================
	always_ff @(posedge clk25 or negedge rst_n) begin
		if (!rst_n) begin
			state     <= ST_IDLE;
			wb_ack    <= 1'b0;
			obs_valid <= 1'b0;
			dq_oe     <= 1'b0;
			sram_ce_n <= 1'b1;
			sram_oe_n <= 1'b1;
			sram_we_n <= 1'b1;
			sram_lb_n <= 1'b1;
			sram_ub_n <= 1'b1;
		end else begin
			wb_ack    <= 1'b0;  // Single-cycle pulses
			obs_valid <= 1'b0;
			case (state)
				ST_IDLE: if (start) begin
					sram_ce_n <= 1'b0;
					sram_lb_n <= 1'b0;  // Reads take the whole word
					sram_ub_n <= 1'b0;
					if (!wb_req.we) begin
						sram_oe_n <= 1'b0;
						state     <= ST_READ;
					end else if (partial) begin
						sram_oe_n <= 1'b0;  // Fetch old word first
						state     <= ST_MERGE_RD;
					end else begin
						sram_we_n <= 1'b0;
						dq_oe     <= 1'b1;
						state     <= ST_WRITE;
					end
				end
				ST_MERGE_RD: begin
					sram_oe_n <= 1'b1;  // Turn the bus around
					sram_we_n <= 1'b0;
					dq_oe     <= 1'b1;
					sram_lb_n <= ~req_q.sel[0];  // Write only the requested lanes
					sram_ub_n <= ~req_q.sel[1];
					state     <= ST_WRITE;
				end
				ST_READ, ST_WRITE: begin
					sram_ce_n <= 1'b1;  // End of access
					sram_oe_n <= 1'b1;
					sram_we_n <= 1'b1;
					sram_lb_n <= 1'b1;
					sram_ub_n <= 1'b1;
					dq_oe     <= 1'b0;
					wb_ack    <= 1'b1;
					obs_valid <= 1'b1;
					state     <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// ==============================
	// Address and data path
	// ==============================
	always_ff @(posedge clk25) begin
		if (start) begin
			req_q   <= wb_req;
			wr_data <= wb_req.dat;
		end
		case (state)
			ST_READ:     data_q  <= sram_dq;  // Sample at end of OE window
			ST_MERGE_RD: wr_data <= lane_merge(req_q.sel, req_q.dat, sram_dq);
			ST_WRITE:    data_q  <= wr_data;  // Full resulting word
			default:     ;
		endcase
	end

	assign sram_addr = req_q.adr;
	assign sram_dq   = dq_oe ? wr_data : {DATA_W{1'bz}};
	assign wb_dat_r  = data_q;

	assign obs = bus_obs_t'{valid: obs_valid, we: req_q.we, fetch: req_q.fetch,
		adr: req_q.adr, dat: data_q};

	// ==============================
	// Checks
	// ==============================
	a_ack_pulse: assert property (@(posedge clk25) disable iff (!rst_n)
		wb_ack |=> !wb_ack);
	a_wr_sel: assert property (@(posedge clk25) disable iff (!rst_n)
		start && wb_req.we |-> wb_req.sel != '0);
	a_no_contention: assert property (@(posedge clk25) disable iff (!rst_n)
		!(!sram_we_n && !sram_oe_n));

endmodule

`default_nettype wire
